/* Bender.yml */
package:
  name: ex_unit

export_include_dirs:
  - .

sources:
  - ex_pkg.sv
  - ex_logic_shift.sv
  - ex_arith.sv
  - ex_mul_hilo.sv
  - ex_result_buf.sv
  - ex_top.sv
  - target: test
    files:
      - tb_ex_top.sv

/* ex_arith.sv */
// arithmetic unit: add and subtract, set-less-than, leading zero and one counts, overflow
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_arith (
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   reg1_i,
    input  ex_pkg::word_t   reg2_i,
    output ex_pkg::word_t   result_o,
    output logic            overflow_o
);

    import ex_pkg::*;

    localparam int MSB = `EX_WORD_W - 1;

    logic  sub_op;
    word_t add_b;
    word_t sum;
    logic  lt_signed;
    logic  lt_unsigned;
    word_t search;
    word_t lead_cnt;

    // subtract as reg1 + ~reg2 + 1
    assign sub_op = (op_i == OP_SUB) || (op_i == OP_SUBU) || (op_i == OP_SLT);
    assign add_b  = sub_op ? ~reg2_i : reg2_i;
    assign sum    = reg1_i + add_b + word_t'(sub_op);

    // same-signed adder inputs, result of the other sign
    assign overflow_o = ((op_i == OP_ADD) || (op_i == OP_SUB)) &&
                        (reg1_i[MSB] == add_b[MSB]) && (sum[MSB] != reg1_i[MSB]);

    // sum holds reg1 - reg2 here
    assign lt_signed   = (reg1_i[MSB] && !reg2_i[MSB]) ||
                         ((reg1_i[MSB] == reg2_i[MSB]) && sum[MSB]);
    assign lt_unsigned = reg1_i < reg2_i;

    // clo counts leading zeros of the inverted word
    assign search = (op_i == OP_CLO) ? ~reg1_i : reg1_i;

    // priority search, highest set bit wins
    always_comb begin
        lead_cnt = word_t'(`EX_WORD_W);
        for (int i = 0; i < `EX_WORD_W; i++) begin
            if (search[i]) begin
                lead_cnt = word_t'(MSB - i);
            end
        end
    end

    always_comb begin
        case (op_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                result_o = sum;
            end
            OP_SLT: begin
                result_o = word_t'(lt_signed);
            end
            OP_SLTU: begin
                result_o = word_t'(lt_unsigned);
            end
            OP_CLZ, OP_CLO: begin
                result_o = lead_cnt;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* ex_defines.svh */
// execute unit sizing macros: word, register address, result buffer and credit limits
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// operand and result width
`define EX_WORD_W 32

// destination register address width
`define EX_ADDR_W 5

// result buffer entries, also the upstream credits held after reset
`define EX_BUF_DEPTH 4

// most downstream credits the unit can hold at once
`define EX_CREDIT_MAX 7

`endif

/* ex_logic_shift.sv */
// logic and shift unit: and, or, xor, nor and the three shifts of reg2 by reg1
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_logic_shift (
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   reg1_i,
    input  ex_pkg::word_t   reg2_i,
    output ex_pkg::word_t   result_o
);

    import ex_pkg::*;

    localparam int SHAMT_W = $clog2(`EX_WORD_W);

    logic [SHAMT_W-1:0] shamt;

    // shift amount comes from the low bits of reg1
    assign shamt = reg1_i[SHAMT_W-1:0];

    always_comb begin
        case (op_i)
            OP_AND: begin
                result_o = reg1_i & reg2_i;
            end
            OP_OR: begin
                result_o = reg1_i | reg2_i;
            end
            OP_XOR: begin
                result_o = reg1_i ^ reg2_i;
            end
            OP_NOR: begin
                result_o = ~(reg1_i | reg2_i);
            end
            OP_SLL: begin
                result_o = reg2_i << shamt;
            end
            OP_SRL: begin
                result_o = reg2_i >> shamt;
            end
            // sign of reg2 fills from the top
            OP_SRA: begin
                result_o = word_t'($signed(reg2_i) >>> shamt);
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* ex_mul_hilo.sv */
// multiplier with the HI/LO pair: mult, multu, mul and the HI/LO moves
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_mul_hilo (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            op_valid_i,
    input  ex_pkg::alu_op_e op_i,
    input  ex_pkg::word_t   reg1_i,
    input  ex_pkg::word_t   reg2_i,
    output ex_pkg::word_t   result_o
);

    import ex_pkg::*;

    localparam int MSB = `EX_WORD_W - 1;

    logic   signed_op;
    word_t  opa;
    word_t  opb;
    dword_t prod_mag;
    dword_t product;
    word_t  hi_q;
    word_t  lo_q;

    assign signed_op = (op_i == OP_MULT) || (op_i == OP_MUL);

    // magnitudes for signed multiply
    assign opa = (signed_op && reg1_i[MSB]) ? ~reg1_i + 1'b1 : reg1_i;
    assign opb = (signed_op && reg2_i[MSB]) ? ~reg2_i + 1'b1 : reg2_i;

    assign prod_mag = dword_t'(opa) * dword_t'(opb);

    // restore the sign when operand signs differ
    assign product = (signed_op && (reg1_i[MSB] ^ reg2_i[MSB])) ? ~prod_mag + 1'b1 : prod_mag;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (op_valid_i) begin
            case (op_i)
                OP_MULT, OP_MULTU: {hi_q, lo_q} <= product;
                OP_MTHI:           hi_q <= reg1_i;
                OP_MTLO:           lo_q <= reg1_i;
                default:           ;
            endcase
        end
    end

    always_comb begin
        case (op_i)
            OP_MFHI: result_o = hi_q;
            OP_MFLO: result_o = lo_q;
            OP_MUL:  result_o = product[MSB:0];
            default: result_o = '0;
        endcase
    end

    // an unknown opcode would corrupt HI/LO at the accepting edge
    a_op_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        op_valid_i |-> !$isunknown(op_i));

endmodule

/* ex_pkg.sv */
// execute unit types: data words, register address, credit count and operation codes
`include "ex_defines.svh"

package ex_pkg;

    typedef logic [`EX_WORD_W-1:0]   word_t;
    typedef logic [2*`EX_WORD_W-1:0] dword_t;
    typedef logic [`EX_ADDR_W-1:0]   reg_addr_t;

    // holds 0 .. EX_CREDIT_MAX
    typedef logic [$clog2(`EX_CREDIT_MAX + 1)-1:0] credit_cnt_t;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MULT,
        OP_MULTU,
        OP_MUL,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

endpackage

/* ex_result_buf.sv */
// in-order result FIFO that returns upstream credits and spends downstream credits
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_result_buf (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              push_i,
    input  ex_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    input  ex_pkg::word_t     wdata_i,
    input  logic              credit_i,
    output logic              credit_o,
    output logic              result_valid_o,
    output ex_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output ex_pkg::word_t     wdata_o
);

    import ex_pkg::*;

    localparam int PTR_W = $clog2(`EX_BUF_DEPTH);
    localparam int CNT_W = $clog2(`EX_BUF_DEPTH + 1);

    reg_addr_t wd_mem    [`EX_BUF_DEPTH];
    logic      wreg_mem  [`EX_BUF_DEPTH];
    word_t     wdata_mem [`EX_BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill_cnt;
    credit_cnt_t      credit_cnt;
    logic             pop;

    // needs an entry and a downstream credit
    assign pop = (fill_cnt != '0) && (credit_cnt != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fill_cnt       <= '0;
            credit_cnt     <= '0;
            result_valid_o <= 1'b0;
            credit_o       <= 1'b0;
            wreg_o         <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(`EX_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`EX_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                wreg_o <= wreg_mem[rd_ptr];
            end
            fill_cnt       <= fill_cnt + CNT_W'(push_i) - CNT_W'(pop);
            credit_cnt     <= credit_cnt + credit_cnt_t'(credit_i) - credit_cnt_t'(pop);
            // each result out frees one slot for the source
            result_valid_o <= pop;
            credit_o       <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            wd_mem[wr_ptr]    <= wd_i;
            wreg_mem[wr_ptr]  <= wreg_i;
            wdata_mem[wr_ptr] <= wdata_i;
        end
        if (pop) begin
            wd_o    <= wd_mem[rd_ptr];
            wdata_o <= wdata_mem[rd_ptr];
        end
    end

    // source pushed without holding a credit
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
        push_i |-> fill_cnt < CNT_W'(`EX_BUF_DEPTH));

    a_credit_limit: assert property (@(posedge clk) disable iff (!arst_n_i)
        (credit_i && !pop) |-> credit_cnt < credit_cnt_t'(`EX_CREDIT_MAX));

    a_reset_quiet: assert property (@(posedge clk) $rose(arst_n_i) |=> !result_valid_o);

endmodule

/* ex_top.sv */
// execute unit top: runs the operation and queues the result for in-order return
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              op_valid_i,
    input  ex_pkg::alu_op_e   op_i,
    input  ex_pkg::word_t     reg1_i,
    input  ex_pkg::word_t     reg2_i,
    input  ex_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    output logic              credit_o,
    input  logic              credit_i,
    output logic              result_valid_o,
    output ex_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output ex_pkg::word_t     wdata_o
);

    import ex_pkg::*;

    word_t ls_res;
    word_t ar_res;
    word_t mh_res;
    word_t ex_res;
    logic  overflow;
    logic  ex_wreg;

    ex_logic_shift i_logic_shift (
        .op_i     (op_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .result_o (ls_res)
    );

    ex_arith i_arith (
        .op_i       (op_i),
        .reg1_i     (reg1_i),
        .reg2_i     (reg2_i),
        .result_o   (ar_res),
        .overflow_o (overflow)
    );

    ex_mul_hilo i_mul_hilo (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .op_valid_i (op_valid_i),
        .op_i       (op_i),
        .reg1_i     (reg1_i),
        .reg2_i     (reg2_i),
        .result_o   (mh_res)
    );

    // result class follows from the opcode
    always_comb begin
        case (op_i)
            OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA: begin
                ex_res = ls_res;
            end
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: begin
                ex_res = ar_res;
            end
            OP_MUL, OP_MFHI, OP_MFLO: begin
                ex_res = mh_res;
            end
            // mult, multu, mthi, mtlo only touch HI/LO
            default: begin
                ex_res = {`EX_WORD_W{1'b0}};
            end
        endcase
    end

    // signed overflow suppresses the register write
    assign ex_wreg = wreg_i && !overflow;

    ex_result_buf i_result_buf (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .push_i         (op_valid_i),
        .wd_i           (wd_i),
        .wreg_i         (ex_wreg),
        .wdata_i        (ex_res),
        .credit_i       (credit_i),
        .credit_o       (credit_o),
        .result_valid_o (result_valid_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .wdata_o        (wdata_o)
    );

endmodule

/* tb.f */
+incdir+.
ex_pkg.sv
ex_logic_shift.sv
ex_arith.sv
ex_mul_hilo.sv
ex_result_buf.sv
ex_top.sv
tb_ex_top.sv

/* tb_ex_top.sv */
// execute unit testbench checking random and directed operations against a reference model
`timescale 1ns/1ps
`include "ex_defines.svh"

module tb_ex_top;

    import ex_pkg::*;

    localparam int N_BP       = `EX_BUF_DEPTH;
    localparam int N_RAND_LS  = 40;
    localparam int N_SHIFT    = 5;
    localparam int N_RAND_AR  = 40;
    localparam int N_LIMITS   = 8;
    localparam int N_RAND_CL  = 16;
    localparam int N_CL_DIR   = 10;
    localparam int N_RAND_MUL = 8;
    localparam int N_MUL_DIR  = 14;
    localparam int NUM_OPS    = N_BP + N_RAND_LS + N_SHIFT + N_RAND_AR + N_LIMITS + N_RAND_CL +
                                N_CL_DIR + 3 * N_RAND_MUL + N_MUL_DIR + 1;
    localparam int TIMEOUT    = NUM_OPS * 4 + 100;
    localparam longint S_MAX  = 64'sd2147483647;
    localparam longint S_MIN  = -64'sd2147483648;

    logic      clk = 1'b0;
    logic      arst_n_i;
    logic      op_valid_i;
    alu_op_e   op_i;
    word_t     reg1_i;
    word_t     reg2_i;
    reg_addr_t wd_i;
    logic      wreg_i;
    logic      credit_o;
    logic      credit_i;
    logic      result_valid_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    word_t     wdata_o;

    integer    seed;
    int        cyc = 0;
    int        sent_cnt = 0;
    int        ret_cnt = 0;
    int        grant_cnt = 0;
    int        rx_cnt = 0;
    int        issue_cyc;
    logic      grant_en;
    dword_t    model_hilo = '0;
    reg_addr_t exp_addr_q[$];
    logic      exp_flag_q[$];
    word_t     exp_word_q[$];
    word_t     cl_vals[5] = '{32'h0, 32'hffff_ffff, 32'h1, 32'h8000_0000, 32'h0001_0000};

    ex_top i_dut (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .reg1_i         (reg1_i),
        .reg2_i         (reg2_i),
        .wd_i           (wd_i),
        .wreg_i         (wreg_i),
        .credit_o       (credit_o),
        .credit_i       (credit_i),
        .result_valid_o (result_valid_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .wdata_o        (wdata_o)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    // expected word and write flag from a private HI/LO pair
    function automatic void ex_model(input alu_op_e op, input word_t a, input word_t b,
                                     input logic wr, output word_t res, output logic wr_o);
        longint sa;
        longint sb;
        dword_t p;
        int     n;
        logic [4:0] sh;
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        sh   = a[4:0];
        n    = 0;
        res  = '0;
        wr_o = wr;
        case (op)
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_XOR:   res = a ^ b;
            OP_NOR:   res = ~(a | b);
            OP_SLL:   res = b << sh;
            OP_SRL:   res = b >> sh;
            OP_SRA:   res = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            OP_ADD, OP_SUB: begin
                p   = dword_t'((op == OP_ADD) ? sa + sb : sa - sb);
                res = p[31:0];
                if (longint'(p) > S_MAX || longint'(p) < S_MIN) begin
                    wr_o = 1'b0;
                end
            end
            OP_ADDU:  res = a + b;
            OP_SUBU:  res = a - b;
            OP_SLT:   res = (sa < sb) ? 32'd1 : 32'd0;
            OP_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
            OP_CLZ, OP_CLO: begin
                while (n < `EX_WORD_W && a[`EX_WORD_W - 1 - n] == (op == OP_CLO)) begin
                    n++;
                end
                res = word_t'(n);
            end
            OP_MULT:  model_hilo = dword_t'(sa * sb);
            OP_MULTU: model_hilo = {32'h0, a} * {32'h0, b};
            OP_MUL: begin
                p   = dword_t'(sa * sb);
                res = p[31:0];
            end
            OP_MFHI:  res = model_hilo[63:32];
            OP_MFLO:  res = model_hilo[31:0];
            OP_MTHI:  model_hilo[63:32] = a;
            OP_MTLO:  model_hilo[31:0] = a;
            default:  res = '0;
        endcase
    endfunction

    // waits for an upstream credit and drives for one cycle
    task automatic send_op(input alu_op_e op, input word_t a, input word_t b, input logic wr);
        reg_addr_t addr;
        word_t     exp_word;
        logic      exp_flag;
        addr = reg_addr_t'($random(seed));
        while (`EX_BUF_DEPTH + ret_cnt - sent_cnt == 0) begin
            @(negedge clk);
        end
        ex_model(op, a, b, wr, exp_word, exp_flag);
        exp_addr_q.push_back(addr);
        exp_flag_q.push_back(exp_flag);
        exp_word_q.push_back(exp_word);
        op_valid_i = 1'b1;
        op_i       = op;
        reg1_i     = a;
        reg2_i     = b;
        wd_i       = addr;
        wreg_i     = wr;
        sent_cnt++;
        issue_cyc = cyc;
        @(negedge clk);
        op_valid_i = 1'b0;
    endtask

    task automatic send_rand(input alu_op_e base, input int span);
        alu_op_e op;
        word_t   a;
        word_t   b;
        logic    wr;
        op = alu_op_e'(int'(base) + int'({$random(seed)} % span));
        a  = word_t'($random(seed));
        b  = word_t'($random(seed));
        wr = 1'($random(seed));
        send_op(op, a, b, wr);
    endtask

    task automatic wait_drain();
        while (exp_word_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cyc++;
        if (arst_n_i) begin
            if (credit_o) begin
                ret_cnt++;
            end
            if (result_valid_o) begin
                rx_cnt++;
            end
        end
        if (cyc > TIMEOUT) begin
            abort_run($sformatf("timeout: run still going after %0d cycles", cyc));
        end
    end

    // downstream sink keeps at most EX_CREDIT_MAX credits outstanding
    always @(negedge clk) begin
        if (grant_en && (grant_cnt - rx_cnt) < `EX_CREDIT_MAX) begin
            credit_i = 1'b1;
            grant_cnt++;
        end else begin
            credit_i = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (arst_n_i && result_valid_o) begin
            if (exp_word_q.size() == 0) begin
                abort_run("a result came out with no operation outstanding");
            end else begin
                check_addr("wd_o", exp_addr_q.pop_front(), wd_o);
                check_flag("wreg_o", exp_flag_q.pop_front(), wreg_o);
                check_word("wdata_o", exp_word_q.pop_front(), wdata_o);
                check_flag("credit_o", 1'b1, credit_o);
            end
        end
    end

    initial begin
        seed       = 32'h4375;
        arst_n_i   = 1'b0;
        op_valid_i = 1'b0;
        op_i       = OP_NOP;
        reg1_i     = '0;
        reg2_i     = '0;
        wd_i       = '0;
        wreg_i     = 1'b0;
        credit_i   = 1'b0;
        grant_en   = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        repeat (4) begin
            @(negedge clk);
            check_flag("result_valid_o", 1'b0, result_valid_o);
            check_flag("credit_o", 1'b0, credit_o);
            check_flag("wreg_o", 1'b0, wreg_o);
        end

        // buffer fills and holds without downstream credits
        repeat (N_BP) send_rand(OP_AND, 7);
        if (`EX_BUF_DEPTH + ret_cnt - sent_cnt != 0) begin
            abort_run("source still holds credits with the result buffer full");
        end
        repeat (8) begin
            @(negedge clk);
            check_flag("result_valid_o", 1'b0, result_valid_o);
        end
        grant_en = 1'b1;

        repeat (N_RAND_LS) send_rand(OP_AND, 7);
        send_op(OP_SRA, 32'd0, 32'h8000_1234, 1'b1);
        send_op(OP_SRA, 32'd31, 32'h9abc_def0, 1'b1);
        send_op(OP_SLL, 32'd31, word_t'($random(seed)), 1'b1);
        send_op(OP_SRL, 32'd31, 32'h8000_0000, 1'b1);
        send_op(OP_SRL, 32'd0, word_t'($random(seed)), 1'b1);

        repeat (N_RAND_AR) send_rand(OP_ADD, 6);
        send_op(OP_ADD, 32'h7fff_ffff, 32'h1, 1'b1);
        send_op(OP_ADD, 32'h8000_0000, 32'hffff_ffff, 1'b1);
        send_op(OP_SUB, 32'h8000_0000, 32'h1, 1'b1);
        send_op(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 1'b1);
        send_op(OP_ADDU, 32'h7fff_ffff, 32'h1, 1'b1);
        send_op(OP_ADDU, 32'h8000_0000, 32'hffff_ffff, 1'b1);
        send_op(OP_SUBU, 32'h8000_0000, 32'h1, 1'b1);
        send_op(OP_SUBU, 32'h7fff_ffff, 32'hffff_ffff, 1'b1);

        repeat (N_RAND_CL) send_rand(OP_CLZ, 2);
        foreach (cl_vals[i]) begin
            send_op(OP_CLZ, cl_vals[i], 32'h0, 1'b1);
            send_op(OP_CLO, cl_vals[i], 32'h0, 1'b1);
        end

        repeat (N_RAND_MUL) begin
            send_rand(OP_MULT, 3);
            send_op(OP_MFHI, 32'h0, 32'h0, 1'b1);
            send_op(OP_MFLO, 32'h0, 32'h0, 1'b1);
        end
        send_op(OP_MULT, 32'h8000_0000, 32'h8000_0000, 1'b0);
        send_op(OP_MFHI, 32'h0, 32'h0, 1'b1);
        send_op(OP_MFLO, 32'h0, 32'h0, 1'b1);
        send_op(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
        send_op(OP_MFHI, 32'h0, 32'h0, 1'b1);
        send_op(OP_MFLO, 32'h0, 32'h0, 1'b1);
        send_op(OP_MULT, 32'h8000_0000, 32'h7fff_ffff, 1'b0);
        send_op(OP_MFHI, 32'h0, 32'h0, 1'b1);
        send_op(OP_MFLO, 32'h0, 32'h0, 1'b1);
        send_op(OP_MUL, 32'h8000_0000, 32'hffff_ffff, 1'b1);
        send_op(OP_MTHI, 32'hdead_0001, 32'h0, 1'b0);
        send_op(OP_MTLO, 32'h0bad_0002, 32'h0, 1'b0);
        send_op(OP_MFHI, 32'h0, 32'h0, 1'b1);
        send_op(OP_MFLO, 32'h0, 32'h0, 1'b1);

        // isolated operation into an empty buffer with credits at hand
        wait_drain();
        repeat (3) @(negedge clk);
        send_op(OP_XOR, word_t'($random(seed)), word_t'($random(seed)), 1'b1);
        while (!result_valid_o) begin
            @(negedge clk);
        end
        if (cyc - issue_cyc != 2) begin
            abort_run($sformatf("isolated result took %0d cycles instead of 2", cyc - issue_cyc));
        end

        wait_drain();
        repeat (4) @(negedge clk);
        if (exp_word_q.size() == 0 && ret_cnt == sent_cnt) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run("results or upstream credits missing at the end of the run");
        end
    end

endmodule
